//--- Makefile
TOP = fifo_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f fifo_config.svh $(wildcard *.sv)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	verilator --lint-only -Wall +incdir+. fifo_data_pkg.sv fifo_ctrl_pkg.sv \
		fifo_ram.sv fifo_ctrl.sv fifo.sv --top-module fifo

clean:
	rm -rf obj_dir $(LOG)

//--- fifo.sv
`timescale 1ns/10ps

module fifo
   import fifo_data_pkg::*;
   import fifo_ctrl_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   wr_en,          // Write strobe, sampled each edge
   input  logic   rd_en,          // Read strobe, sampled each edge
   input  logic   clear,          // Drops overflow and underflow
   input  data_t  wr_data,
   output data_t  rd_data,        // Word of the last accepted read
   output count_t count,
   output logic   full,
   output logic   empty,
   output logic   almost_full,
   output logic   almost_empty,
   output logic   overflow,
   output logic   underflow
);

   logic wr_accept;               // Qualified write, control to storage
   logic rd_accept;               // Qualified read, control to storage
   ptr_t wr_ptr;
   ptr_t rd_ptr;

   // Bookkeeping: pointers, count, flags, sticky errors
   fifo_ctrl u_ctrl (
      .clk          (clk),
      .reset        (reset),
      .wr_en        (wr_en),
      .rd_en        (rd_en),
      .clear        (clear),
      .wr_accept    (wr_accept),
      .rd_accept    (rd_accept),
      .wr_ptr       (wr_ptr),
      .rd_ptr       (rd_ptr),
      .count        (count),
      .full         (full),
      .empty        (empty),
      .almost_full  (almost_full),
      .almost_empty (almost_empty),
      .overflow     (overflow),
      .underflow    (underflow)
   );

   // Storage with registered read port
   fifo_ram u_ram (
      .clk       (clk),
      .wr_accept (wr_accept),
      .wr_ptr    (wr_ptr),
      .wr_data   (wr_data),
      .rd_accept (rd_accept),
      .rd_ptr    (rd_ptr),
      .rd_data   (rd_data)
   );

endmodule

//--- fifo_asserts.sv
`timescale 1ns/10ps
`include "fifo_config.svh"

module fifo_asserts
   import fifo_ctrl_pkg::*;
(
   input logic   clk,
   input logic   reset,
   input logic   wr_en,
   input logic   rd_en,
   input logic   clear,
   input logic   full,
   input logic   empty,
   input count_t count,
   input logic   overflow,
   input ptr_t   wr_ptr,
   input ptr_t   rd_ptr
);

   int unsigned failures = 0;   // Failed properties so far

   // A FIFO cannot be full and empty at once
   full_not_empty: assert property (@(posedge clk) disable iff (reset)
      !(full && empty)) else begin
         $error("full and empty are high together");
         failures++;
      end

   // Occupancy is bounded by the depth
   count_in_range: assert property (@(posedge clk) disable iff (reset)
      count <= count_t'(`FIFO_DEPTH)) else begin
         $error("count is above the FIFO depth");
         failures++;
      end

   // A refused write at full without a read leaves occupancy alone
   write_at_full: assert property (@(posedge clk) disable iff (reset)
      (wr_en && full && !rd_en) |=> $stable(count)) else begin
         $error("count changed after a write while full");
         failures++;
      end

   // Sticky until clear
   overflow_sticky: assert property (@(posedge clk) disable iff (reset)
      (overflow && !clear) |=> overflow) else begin
         $error("overflow dropped without clear");
         failures++;
      end

   // Pointers meet at both ends
   ptr_meet: assert property (@(posedge clk) disable iff (reset)
      (full || empty) |-> (wr_ptr == rd_ptr)) else begin
         $error("pointers differ while full or empty");
         failures++;
      end

endmodule

//--- fifo_config.svh
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// Top-level FIFO configuration, shared by the packages and the RTL

// Bits per stored entry
`define FIFO_WIDTH 8

// Number of entries, must be a power of two so the pointers wrap on their own
`define FIFO_DEPTH 16

// almost_full is high at or above this occupancy
`define FIFO_ALMOST_FULL 12

// almost_empty is high at or below this occupancy
`define FIFO_ALMOST_EMPTY 4

`endif

//--- fifo_ctrl.sv
`timescale 1ns/10ps
`include "fifo_config.svh"

module fifo_ctrl
   import fifo_ctrl_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   wr_en,          // Write request level
   input  logic   rd_en,          // Read request level
   input  logic   clear,          // Clears the sticky error flags
   output logic   wr_accept,      // Write taken this edge
   output logic   rd_accept,      // Read taken this edge
   output ptr_t   wr_ptr,         // Next slot to write
   output ptr_t   rd_ptr,         // Next slot to read
   output count_t count,          // Occupancy
   output logic   full,
   output logic   empty,
   output logic   almost_full,
   output logic   almost_empty,
   output logic   overflow,       // Sticky, write tried while full
   output logic   underflow       // Sticky, read tried while empty
);

   // Occupancy levels as count values
   localparam count_t FULL_COUNT  = count_t'(`FIFO_DEPTH);
   localparam count_t AF_LEVEL    = count_t'(`FIFO_ALMOST_FULL);
   localparam count_t AE_LEVEL    = count_t'(`FIFO_ALMOST_EMPTY);

   ptr_t   wr_ptr_q;              // Write pointer register
   ptr_t   rd_ptr_q;              // Read pointer register
   ptr_t   wr_ptr_next;
   ptr_t   rd_ptr_next;

   count_t count_q;               // Occupancy register
   count_t count_next;            // Occupancy after this edge

   logic   full_q;
   logic   empty_q;
   logic   almost_full_q;
   logic   almost_empty_q;

   logic   overflow_q;
   logic   underflow_q;

   logic   wr_refused;            // Write request dropped this edge
   logic   rd_refused;            // Read request dropped this edge

   // Acceptance
   // Decided from the registered flags, so a read at full frees no room
   // for a write in the same edge and a write at empty feeds no read
   assign wr_accept  = wr_en && !full_q;
   assign rd_accept  = rd_en && !empty_q;

   assign wr_refused = wr_en && full_q;      // Lost write
   assign rd_refused = rd_en && empty_q;     // Lost read

   // Pointer advance
   always_comb begin
      wr_ptr_next = wr_ptr_q;
      rd_ptr_next = rd_ptr_q;
      if (wr_accept) begin
         wr_ptr_next = wr_ptr_q + ptr_t'(1);   // Wraps at depth, power of two
      end
      if (rd_accept) begin
         rd_ptr_next = rd_ptr_q + ptr_t'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         wr_ptr_q <= wr_ptr_next;
         rd_ptr_q <= rd_ptr_next;
      end
   end

   // Occupancy
   always_comb begin
      case ({wr_accept, rd_accept})
         2'b10:   count_next = count_q + count_t'(1);   // Write only
         2'b01:   count_next = count_q - count_t'(1);   // Read only
         default: count_next = count_q;                 // None, or both
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         count_q <= '0;
      end else begin
         count_q <= count_next;
      end
   end

   // Flags
   // Taken from the next count so they change on the same edge as count
   always_ff @(posedge clk) begin
      if (reset) begin
         full_q         <= 1'b0;
         empty_q        <= 1'b1;   // Nothing stored
         almost_full_q  <= 1'b0;
         almost_empty_q <= 1'b1;   // Zero is below the low threshold
      end else begin
         full_q         <= (count_next == FULL_COUNT);
         empty_q        <= (count_next == '0);
         almost_full_q  <= (count_next >= AF_LEVEL);
         almost_empty_q <= (count_next <= AE_LEVEL);
      end
   end

   // Sticky errors
   // clear wins over a refusal in the same cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         overflow_q  <= 1'b0;
         underflow_q <= 1'b0;
      end else if (clear) begin
         overflow_q  <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         if (wr_refused) begin
            overflow_q  <= 1'b1;   // Held until clear
         end
         if (rd_refused) begin
            underflow_q <= 1'b1;
         end
      end
   end

   // Outputs
   assign wr_ptr       = wr_ptr_q;
   assign rd_ptr       = rd_ptr_q;
   assign count        = count_q;
   assign full         = full_q;
   assign empty        = empty_q;
   assign almost_full  = almost_full_q;
   assign almost_empty = almost_empty_q;
   assign overflow     = overflow_q;
   assign underflow    = underflow_q;

endmodule

//--- fifo_ctrl_pkg.sv
`include "fifo_config.svh"

// Types that describe the FIFO bookkeeping: addresses and occupancy
package fifo_ctrl_pkg;

   localparam int PTR_W = $clog2(`FIFO_DEPTH);   // Address bits
   localparam int COUNT_W = PTR_W + 1;           // Room for 0 .. FIFO_DEPTH

   // Storage address, wraps at FIFO_DEPTH
   typedef logic [PTR_W-1:0] ptr_t;

   // Occupancy count, one bit wider so a full FIFO is representable
   typedef logic [COUNT_W-1:0] count_t;

endpackage

//--- fifo_data_pkg.sv
`include "fifo_config.svh"

// Types that describe the payload held in the FIFO
package fifo_data_pkg;

   localparam int DATA_W = `FIFO_WIDTH;   // Bits per entry

   // One stored word
   typedef logic [DATA_W-1:0] data_t;

   // Value of the read port before the first accepted read
   localparam data_t DATA_ZERO = '0;

endpackage

//--- fifo_ram.sv
`timescale 1ns/10ps
`include "fifo_config.svh"

module fifo_ram
   import fifo_data_pkg::*;
   import fifo_ctrl_pkg::*;
(
   input  logic  clk,
   input  logic  wr_accept,   // Write already qualified by the control block
   input  ptr_t  wr_ptr,      // Slot to write
   input  data_t wr_data,     // Word to store
   input  logic  rd_accept,   // Read already qualified by the control block
   input  ptr_t  rd_ptr,      // Slot to read
   output data_t rd_data      // Registered read word
);

   data_t mem [`FIFO_DEPTH];          // Storage array
   data_t rd_data_q = DATA_ZERO;      // Read port register, zero until first read

   // Write port
   // One word per edge, no condition of its own
   always_ff @(posedge clk) begin
      if (wr_accept) begin
         mem[wr_ptr] <= wr_data;      // Store at the write pointer
      end
   end

   // Read port
   // Old contents are returned when the same slot is written this edge,
   // so a new word is visible one edge after it was written
   always_ff @(posedge clk) begin
      if (rd_accept) begin
         rd_data_q <= mem[rd_ptr];    // Capture the head entry
      end
   end

   assign rd_data = rd_data_q;        // Holds between accepted reads

endmodule

//--- fifo_tb.sv
`timescale 1ns/10ps
`include "fifo_config.svh"

module fifo_tb
   import fifo_data_pkg::*;
   import fifo_ctrl_pkg::*;
();

   localparam int unsigned SEED = 32'h1dd8_f2fd;
   localparam int TIMEOUT_CYCLES = 2000;   // Tests take about 620 cycles
   localparam int STRESS_CYCLES = 500;

   logic   clk = 1'b0;
   logic   reset = 1'b1;             // Held through the first three edges
   logic   wr_en = 1'b0;
   logic   rd_en = 1'b0;
   logic   clear = 1'b0;
   data_t  wr_data = '0;
   data_t  rd_data;
   count_t count;
   logic   full;
   logic   empty;
   logic   almost_full;
   logic   almost_empty;
   logic   overflow;
   logic   underflow;

   data_t  model_q[$];               // Expected contents with the head at index 0
   data_t  model_rd_data = '0;       // Expected read port value
   logic   model_overflow = 1'b0;
   logic   model_underflow = 1'b0;

   string  test_name = "none";
   int     data_errors = 0;
   int     count_errors = 0;
   int     flag_errors = 0;
   int     cycles = 0;

   fifo dut (
      .clk          (clk),
      .reset        (reset),
      .wr_en        (wr_en),
      .rd_en        (rd_en),
      .clear        (clear),
      .wr_data      (wr_data),
      .rd_data      (rd_data),
      .count        (count),
      .full         (full),
      .empty        (empty),
      .almost_full  (almost_full),
      .almost_empty (almost_empty),
      .overflow     (overflow),
      .underflow    (underflow)
   );

   // Flag and pointer checks on every fifo instance
   bind fifo fifo_asserts u_asserts (
      .clk      (clk),
      .reset    (reset),
      .wr_en    (wr_en),
      .rd_en    (rd_en),
      .clear    (clear),
      .full     (full),
      .empty    (empty),
      .count    (count),
      .overflow (overflow),
      .wr_ptr   (wr_ptr),
      .rd_ptr   (rd_ptr)
   );

   always #20 clk = ~clk;            // 40 ns period

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic check_data(input string what, input data_t expected, input data_t actual);
      if (actual !== expected) begin
         data_errors++;
         $display("Error %s %s: expected %h, actual %h at %0t",
                  test_name, what, expected, actual, $time);
      end
   endtask

   task automatic check_count(input string what, input count_t expected, input count_t actual);
      if (actual !== expected) begin
         count_errors++;
         $display("Error %s %s: expected %0d, actual %0d at %0t",
                  test_name, what, expected, actual, $time);
      end
   endtask

   task automatic check_flag(input string what, input logic expected, input logic actual);
      if (actual !== expected) begin
         flag_errors++;
         $display("Error %s %s: expected %b, actual %b at %0t",
                  test_name, what, expected, actual, $time);
      end
   endtask

   // All outputs against the queue model
   task automatic compare_outputs();
      check_count("count", count_t'(model_q.size()), count);
      check_flag("full", model_q.size() == `FIFO_DEPTH, full);
      check_flag("empty", model_q.size() == 0, empty);
      check_flag("almost_full", model_q.size() >= `FIFO_ALMOST_FULL, almost_full);
      check_flag("almost_empty", model_q.size() <= `FIFO_ALMOST_EMPTY, almost_empty);
      check_flag("overflow", model_overflow, overflow);
      check_flag("underflow", model_underflow, underflow);
      check_data("rd_data", model_rd_data, rd_data);
   endtask

   // One rising edge of the reference model
   function automatic void update_model(input logic wr, input logic rd, input data_t data,
                                        input logic clr);
      int   n;
      logic wr_take;
      logic rd_take;
      n = model_q.size();
      wr_take = wr && (n != `FIFO_DEPTH);   // Full refuses the write
      rd_take = rd && (n != 0);             // Empty refuses the read
      if (rd_take) begin
         model_rd_data = model_q.pop_front();  // Head leaves before the new word lands
      end
      if (wr_take) begin
         model_q.push_back(data);
      end
      if (clr) begin
         model_overflow = 1'b0;              // Clear beats a new refusal
         model_underflow = 1'b0;
      end else begin
         if (wr && n == `FIFO_DEPTH) begin
            model_overflow = 1'b1;
         end
         if (rd && n == 0) begin
            model_underflow = 1'b1;
         end
      end
   endfunction

   // Entered right after a rising edge. Drives one operation, checks the
   // previous edge's result at the falling edge, then lets the DUT take it
   task automatic apply_cycle(input logic wr, input logic rd, input data_t data,
                              input logic clr);
      wr_en <= wr;
      rd_en <= rd;
      wr_data <= data;
      clear <= clr;
      @(negedge clk);
      compare_outputs();                  // Outputs are settled here
      @(posedge clk);
      update_model(wr, rd, data, clr);
   endtask

   task automatic reset_state();
      test_name = "reset_state";
      repeat (3) @(posedge clk);
      reset <= 1'b0;                      // Released after the third edge
      @(negedge clk);
      check_flag("empty", 1'b1, empty);
      check_flag("almost_empty", 1'b1, almost_empty);
      compare_outputs();                  // Zero count, low flags, zero rd_data
      @(posedge clk);
   endtask

   task automatic fill_and_drain();
      test_name = "fill_and_drain";
      for (int i = 0; i < `FIFO_DEPTH; i++) begin
         apply_cycle(1'b1, 1'b0, data_t'($urandom), 1'b0);
      end
      for (int i = 0; i < `FIFO_DEPTH; i++) begin
         apply_cycle(1'b0, 1'b1, '0, 1'b0);   // Words return in write order
      end
      apply_cycle(1'b0, 1'b0, '0, 1'b0);
   endtask

   task automatic write_when_full();
      test_name = "write_when_full";
      for (int i = 0; i < `FIFO_DEPTH; i++) begin
         apply_cycle(1'b1, 1'b0, data_t'($urandom), 1'b0);
      end
      apply_cycle(1'b1, 1'b0, data_t'($urandom), 1'b0);   // Refused and overflow sets
      apply_cycle(1'b1, 1'b0, data_t'($urandom), 1'b0);   // Still refused
      apply_cycle(1'b0, 1'b0, '0, 1'b1);                  // Clear
      for (int i = 0; i < `FIFO_DEPTH; i++) begin
         apply_cycle(1'b0, 1'b1, '0, 1'b0);   // Contents untouched by the refusals
      end
      apply_cycle(1'b0, 1'b0, '0, 1'b0);
   endtask

   task automatic read_when_empty();
      test_name = "read_when_empty";
      apply_cycle(1'b0, 1'b1, '0, 1'b0);   // Refused while rd_data holds
      apply_cycle(1'b0, 1'b1, '0, 1'b0);
      apply_cycle(1'b0, 1'b0, '0, 1'b1);   // Clear
      apply_cycle(1'b0, 1'b1, '0, 1'b1);   // Refusal and clear together
      apply_cycle(1'b0, 1'b0, '0, 1'b0);
   endtask

   task automatic read_write_together();
      test_name = "read_write_together";
      for (int i = 0; i < 8; i++) begin
         apply_cycle(1'b1, 1'b0, data_t'($urandom), 1'b0);
      end
      for (int i = 0; i < 6; i++) begin
         apply_cycle(1'b1, 1'b1, data_t'($urandom), 1'b0);   // Count stays at 8
      end
      while (model_q.size() < `FIFO_DEPTH) begin
         apply_cycle(1'b1, 1'b0, data_t'($urandom), 1'b0);
      end
      apply_cycle(1'b1, 1'b1, data_t'($urandom), 1'b0);   // Read taken and write refused at full
      apply_cycle(1'b0, 1'b0, '0, 1'b1);
      while (model_q.size() > 0) begin
         apply_cycle(1'b0, 1'b1, '0, 1'b0);
      end
      apply_cycle(1'b1, 1'b1, data_t'($urandom), 1'b0);   // Write taken and read refused at empty
      apply_cycle(1'b0, 1'b1, '0, 1'b1);                  // Read it back and clear underflow
      apply_cycle(1'b0, 1'b0, '0, 1'b0);
   endtask

   task automatic random_stress();
      logic        wr;
      logic        rd;
      logic        clr;
      data_t       data;
      int unsigned write_odds;
      test_name = "random_stress";
      for (int i = 0; i < STRESS_CYCLES; i++) begin
         write_odds = (i < STRESS_CYCLES / 2) ? 3 : 1;   // Lean to full and then to empty
         wr = ($urandom % 4) < write_odds;
         rd = ($urandom % 4) >= write_odds;
         clr = ($urandom % 32) == 0;
         data = data_t'($urandom);
         apply_cycle(wr, rd, data, clr);
      end
      apply_cycle(1'b0, 1'b0, '0, 1'b0);
   endtask

   initial begin
      void'($urandom(SEED));
      reset_state();
      fill_and_drain();
      write_when_full();
      read_when_empty();
      read_write_together();
      random_stress();
      test_name = "final";
      @(negedge clk);
      compare_outputs();                  // Result of the last idle cycle
      $display("Errors: data %0d, count %0d, flag %0d, assertion %0d", data_errors,
               count_errors, flag_errors, dut.u_asserts.failures);
      if (data_errors + count_errors + flag_errors + dut.u_asserts.failures == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- sources.f
+incdir+.
fifo_data_pkg.sv
fifo_ctrl_pkg.sv
fifo_ram.sv
fifo_ctrl.sv
fifo.sv
fifo_asserts.sv
fifo_tb.sv
